/* hw/hpd_consts.svh */
`ifndef HPD_CONSTS_SVH
`define HPD_CONSTS_SVH

// Sink ports, one detector each
`define HPD_PORTS 4

// Queue slots owned by each port
`define HPD_CREDITS 2
`define HPD_QUEUE_DEPTH (`HPD_PORTS * `HPD_CREDITS)

// Beat counter width, enough for the unplug time
`define HPD_CNT_W 11

// Beat on every second clock
`define HPD_BEAT_DIV 2

// Thresholds in beats scaled down by ten
`define HPD_PLUG_THRES 25
`define HPD_PULSE_THRES 50
`define HPD_UNPLUG_THRES 200

`endif

/* hw/dp_hpd_pkg.sv */
package dp_hpd_pkg;

    // Filter states
    typedef enum logic [2:0]
    {
        st_rst,
        st_unplug_init,
        st_unplug,
        st_plug_init,
        st_plug,
        st_pulse_init,
        st_pulse
    } hpd_state_e;

    // Event kinds, zero is never queued
    typedef enum logic [1:0]
    {
        evt_none   = 2'd0,
        evt_unplug = 2'd1,
        evt_plug   = 2'd2,
        evt_pulse  = 2'd3
    } hpd_evt_kind_e;

    // Queue entry
    typedef struct packed
    {
        logic [1:0]    port;
        hpd_evt_kind_e kind;
    } hpd_evt_s;

endpackage

/* hw/dp_lb_pkg.sv */
`include "hpd_consts.svh"

package dp_lb_pkg;

    // Register map
    typedef enum logic [1:0]
    {
        lb_adr_ctl = 2'd0,
        lb_adr_sta = 2'd1,
        lb_adr_pop = 2'd2
    } lb_adr_e;

    // Control, written and read back at address 0
    typedef struct packed
    {
        logic [29-`HPD_PORTS:0] rsvd;
        logic [`HPD_PORTS-1:0]  force_hpd;
        logic                   ie;
        logic                   run;
    } ctl_word_s;

    // Status address, write side
    typedef struct packed
    {
        logic [29-`HPD_PORTS:0] rsvd;
        logic [`HPD_PORTS-1:0]  ovf_clr;
        logic                   rsvd_1;
        logic                   irq_clr;
    } sta_clr_s;

    // Status address, read side
    typedef struct packed
    {
        logic [29-2*`HPD_PORTS:0] rsvd;
        logic [`HPD_PORTS-1:0]    ovf;
        logic [`HPD_PORTS-1:0]    lvl;
        logic                     empty;
        logic                     irq;
    } sta_word_s;

    // One write word, two decodes
    typedef union packed
    {
        ctl_word_s ctl;
        sta_clr_s  clr;
    } lb_word_u;

endpackage

/* hw/hpd_evt_if.sv */
`timescale 1ns/1ps

interface hpd_evt_if;

    // One-cycle event strobe and its kind
    logic                      evt_vld;
    dp_hpd_pkg::hpd_evt_kind_e evt_kind;

    // Credit back from the queue on pop
    logic                      crd_ret;

    // Sticky loss flag, read in status
    logic                      ovf;

    // Detector side
    modport src
    (
        output evt_vld,
        output evt_kind,
        output ovf,
        input  crd_ret
    );

    // Queue side
    modport snk
    (
        input  evt_vld,
        input  evt_kind,
        input  ovf,
        output crd_ret
    );

endinterface

/* hw/hpd_lb_regs.sv */
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_lb_regs
(
    input  logic                   CLK_IN,
    input  logic                   RST_IN,
    input  logic [1:0]             lb_adr,
    input  logic                   lb_wr,
    input  logic                   lb_rd,
    input  logic [31:0]            lb_din,
    output logic [31:0]            lb_dout,
    output logic                   lb_vld,
    output logic                   beat,
    output logic                   run,
    output logic                   ie,
    output logic [`HPD_PORTS-1:0]  force_hpd,
    output logic [`HPD_PORTS-1:0]  ovf_clr,
    output logic                   pop,
    output logic                   irq_clr,
    input  logic [`HPD_PORTS-1:0]  hpd_lvl,
    input  logic [`HPD_PORTS-1:0]  ovf,
    input  dp_hpd_pkg::hpd_evt_s   head,
    input  logic                   empty,
    input  logic                   irq_in
);

    localparam int BEAT_W = $clog2(`HPD_BEAT_DIV);

    dp_lb_pkg::lb_adr_e    adr_q;
    logic                  wr_q;
    logic                  rd_q;
    dp_lb_pkg::lb_word_u   wdat;
    dp_lb_pkg::ctl_word_s  ctl_q;
    dp_lb_pkg::sta_word_s  sta;
    logic                  sta_wr;
    logic [BEAT_W-1:0]     beat_cnt;

    // Request strobes
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end
        else
        begin
            wr_q <= lb_wr;
            rd_q <= lb_rd;
        end
    end

    // Address and data
    always_ff @(posedge CLK_IN)
    begin
        adr_q <= dp_lb_pkg::lb_adr_e'(lb_adr);
        wdat  <= lb_din;
    end

    // Beat divider, one pulse per HPD_BEAT_DIV clocks
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            beat_cnt <= '0;
            beat     <= 1'b0;
        end
        else if (beat_cnt == BEAT_W'(`HPD_BEAT_DIV - 1))
        begin
            beat_cnt <= '0;
            beat     <= 1'b1;
        end
        else
        begin
            beat_cnt <= beat_cnt + 1'b1;
            beat     <= 1'b0;
        end
    end

    // Control register, reserved bits kept at zero
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            ctl_q <= '0;
        else if (wr_q && adr_q == dp_lb_pkg::lb_adr_ctl)
        begin
            ctl_q.run       <= wdat.ctl.run;
            ctl_q.ie        <= wdat.ctl.ie;
            ctl_q.force_hpd <= wdat.ctl.force_hpd;
        end
    end

    assign run       = ctl_q.run;
    assign ie        = ctl_q.ie;
    assign force_hpd = ctl_q.force_hpd;

    // Clear pulses via the status address
    assign sta_wr  = wr_q && adr_q == dp_lb_pkg::lb_adr_sta;
    assign irq_clr = sta_wr && wdat.clr.irq_clr;
    assign ovf_clr = sta_wr ? wdat.clr.ovf_clr : '0;

    // Pop read removes the head this cycle
    assign pop    = rd_q && adr_q == dp_lb_pkg::lb_adr_pop;
    assign lb_vld = rd_q;

    // Read mux
    always_comb
    begin
        sta       = '0;
        sta.irq   = irq_in;
        sta.empty = empty;
        sta.lvl   = hpd_lvl;
        sta.ovf   = ovf;
        lb_dout   = '0;
        case (adr_q)
            dp_lb_pkg::lb_adr_ctl : lb_dout = ctl_q;
            dp_lb_pkg::lb_adr_sta : lb_dout = sta;
            dp_lb_pkg::lb_adr_pop :
            begin
                // Empty flag in bit 8, head zeroed when empty
                if (!empty)
                    lb_dout[$bits(head)-1:0] = head;
                lb_dout[8] = empty;
            end
            default : lb_dout = '0;
        endcase
    end

endmodule

/* hw/hpd_detector.sv */
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_detector
(
    input  logic   CLK_IN,
    input  logic   RST_IN,
    input  logic   beat,
    input  logic   run,
    input  logic   force_hpd,
    input  logic   hpd_raw,
    input  logic   ovf_clr,
    output logic   hpd_lvl,
    hpd_evt_if.src evt
);

    localparam int CRD_W = $clog2(`HPD_CREDITS + 1);
    localparam logic [`HPD_CNT_W-1:0] PLUG_THRES   = `HPD_PLUG_THRES;
    localparam logic [`HPD_CNT_W-1:0] PULSE_THRES  = `HPD_PULSE_THRES;
    localparam logic [`HPD_CNT_W-1:0] UNPLUG_THRES = `HPD_UNPLUG_THRES;

    dp_hpd_pkg::hpd_state_e    st_cur;
    dp_hpd_pkg::hpd_state_e    st_nxt;
    logic [`HPD_CNT_W-1:0]     cnt;
    logic                      cnt_clr;
    logic                      cnt_inc;
    logic                      det_set;
    dp_hpd_pkg::hpd_evt_kind_e det_kind;
    logic                      det_evt;
    logic                      slot_free;
    logic                      pend_vld;
    dp_hpd_pkg::hpd_evt_kind_e pend_kind;
    logic                      send;
    logic [CRD_W-1:0]          crd;
    logic                      ovf_q;

    // Filtered level, force wins over the pin
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            hpd_lvl <= 1'b0;
        else
            hpd_lvl <= force_hpd | hpd_raw;
    end

    // State register, moves on beat only
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            st_cur <= dp_hpd_pkg::st_rst;
        else if (!run)
            st_cur <= dp_hpd_pkg::st_rst;
        else if (beat)
            st_cur <= st_nxt;
    end

    // Next state and event decode
    always_comb
    begin
        cnt_clr  = 1'b0;
        cnt_inc  = 1'b0;
        det_set  = 1'b0;
        det_kind = dp_hpd_pkg::evt_none;
        st_nxt   = st_cur;
        case (st_cur)
            // Starting up counts as unplugged
            dp_hpd_pkg::st_rst :
            begin
                cnt_clr  = 1'b1;
                det_set  = 1'b1;
                det_kind = dp_hpd_pkg::evt_unplug;
                st_nxt   = dp_hpd_pkg::st_unplug_init;
            end
            dp_hpd_pkg::st_unplug_init : st_nxt = dp_hpd_pkg::st_unplug;
            // Waiting for a steady high
            dp_hpd_pkg::st_unplug :
            begin
                if (!hpd_lvl)
                begin
                    cnt_clr = 1'b1;
                    st_nxt  = dp_hpd_pkg::st_unplug_init;
                end
                else if (cnt >= PLUG_THRES)
                begin
                    cnt_clr  = 1'b1;
                    det_set  = 1'b1;
                    det_kind = dp_hpd_pkg::evt_plug;
                    st_nxt   = dp_hpd_pkg::st_plug_init;
                end
                else
                    cnt_inc = 1'b1;
            end
            dp_hpd_pkg::st_plug_init : st_nxt = dp_hpd_pkg::st_plug;
            // Short lows are glitches
            dp_hpd_pkg::st_plug :
            begin
                if (hpd_lvl)
                begin
                    cnt_clr = 1'b1;
                    st_nxt  = dp_hpd_pkg::st_plug_init;
                end
                else
                begin
                    cnt_inc = 1'b1;
                    if (cnt >= PULSE_THRES)
                        st_nxt = dp_hpd_pkg::st_pulse_init;
                end
            end
            // Low time keeps counting towards unplug
            dp_hpd_pkg::st_pulse_init :
            begin
                cnt_inc = 1'b1;
                st_nxt  = dp_hpd_pkg::st_pulse;
            end
            dp_hpd_pkg::st_pulse :
            begin
                if (hpd_lvl)
                begin
                    // Back high before timeout
                    cnt_clr  = 1'b1;
                    det_set  = 1'b1;
                    det_kind = dp_hpd_pkg::evt_pulse;
                    st_nxt   = dp_hpd_pkg::st_plug_init;
                end
                else if (cnt >= UNPLUG_THRES)
                begin
                    cnt_clr  = 1'b1;
                    det_set  = 1'b1;
                    det_kind = dp_hpd_pkg::evt_unplug;
                    st_nxt   = dp_hpd_pkg::st_unplug_init;
                end
                else
                    cnt_inc = 1'b1;
            end
            default : st_nxt = dp_hpd_pkg::st_rst;
        endcase
    end

    // Beat counter
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            cnt <= '0;
        else if (!run)
            cnt <= '0;
        else if (beat && cnt_clr)
            cnt <= '0;
        else if (beat && cnt_inc)
            cnt <= cnt + 1'b1;
    end

    // Event leaves when a credit is held
    assign det_evt   = beat && det_set && run;
    assign send      = pend_vld && (crd != '0);
    assign slot_free = !pend_vld || send;

    // Pending slot, credits and overflow
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            pend_vld <= 1'b0;
            crd      <= CRD_W'(`HPD_CREDITS);
            ovf_q    <= 1'b0;
        end
        else if (!run)
        begin
            pend_vld <= 1'b0;
            crd      <= CRD_W'(`HPD_CREDITS);
            ovf_q    <= 1'b0;
        end
        else
        begin
            if (det_evt && slot_free)
                pend_vld <= 1'b1;
            else if (send)
                pend_vld <= 1'b0;
            // Loss beats a clear in the same cycle
            if (det_evt && !slot_free)
                ovf_q <= 1'b1;
            else if (ovf_clr)
                ovf_q <= 1'b0;
            crd <= crd - CRD_W'(send) + CRD_W'(evt.crd_ret);
        end
    end

    // Kind payload
    always_ff @(posedge CLK_IN)
    begin
        if (det_evt && slot_free)
            pend_kind <= det_kind;
    end

    assign evt.evt_vld  = send;
    assign evt.evt_kind = pend_kind;
    assign evt.ovf      = ovf_q;

    // Queue hands back no more credits than were spent
    a_crd_max : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        crd <= CRD_W'(`HPD_CREDITS));
    a_crd_ret : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        evt.crd_ret |-> crd != CRD_W'(`HPD_CREDITS));

endmodule

/* hw/hpd_event_queue.sv */
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_event_queue
(
    input  logic                  CLK_IN,
    input  logic                  RST_IN,
    input  logic                  run,
    input  logic                  pop,
    input  logic                  irq_clr,
    input  logic                  ie,
    hpd_evt_if.snk                evt [`HPD_PORTS],
    output dp_hpd_pkg::hpd_evt_s  head,
    output logic                  empty,
    output logic                  irq,
    output logic [`HPD_PORTS-1:0] ovf
);

    localparam int PTR_W = $clog2(`HPD_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`HPD_QUEUE_DEPTH + 1);

    logic [`HPD_PORTS-1:0]     vld;
    dp_hpd_pkg::hpd_evt_kind_e kind [`HPD_PORTS];
    logic [`HPD_PORTS-1:0]     held;
    dp_hpd_pkg::hpd_evt_kind_e held_kind [`HPD_PORTS];
    logic [`HPD_PORTS-1:0]     req;
    dp_hpd_pkg::hpd_evt_kind_e req_kind [`HPD_PORTS];
    logic [1:0]                win;
    dp_hpd_pkg::hpd_evt_s      wr_evt;
    logic                      wr_en;
    logic                      wr_q;
    logic                      rd_en;
    dp_hpd_pkg::hpd_evt_s      mem [`HPD_QUEUE_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          cnt;

    // Unpack the ports, credit back to the head's owner
    for (genvar i = 0; i < `HPD_PORTS; i++)
    begin : g_port
        assign vld[i]         = evt[i].evt_vld;
        assign kind[i]        = evt[i].evt_kind;
        assign ovf[i]         = evt[i].ovf;
        assign req[i]         = vld[i] | held[i];
        assign req_kind[i]    = held[i] ? held_kind[i] : kind[i];
        assign evt[i].crd_ret = rd_en && head.port == 2'(i);

        // A port never strobes while its last event waits
        a_no_clash : assert property (@(posedge CLK_IN) disable iff (RST_IN)
            held[i] |-> !vld[i]);
    end

    // Fixed priority, lowest port first
    always_comb
    begin
        win = '0;
        for (int i = `HPD_PORTS - 1; i >= 0; i--)
        begin
            if (req[i])
                win = 2'(i);
        end
    end

    assign wr_en  = run && (req != '0);
    assign rd_en  = run && pop && !empty;
    assign wr_evt = '{port: win, kind: req_kind[win]};

    // Losers wait in held
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            held <= '0;
        else if (!run)
            held <= '0;
        else
        begin
            for (int i = 0; i < `HPD_PORTS; i++)
                held[i] <= req[i] && win != 2'(i);
        end
    end

    always_ff @(posedge CLK_IN)
    begin
        for (int i = 0; i < `HPD_PORTS; i++)
        begin
            if (vld[i])
                held_kind[i] <= kind[i];
        end
        if (wr_en)
            mem[wr_ptr] <= wr_evt;
    end

    // FIFO pointers and fill level, flushed when run drops
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            wr_q   <= 1'b0;
        end
        else if (!run)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            wr_q   <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            cnt  <= cnt + CNT_W'(wr_en) - CNT_W'(rd_en);
            wr_q <= wr_en;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = cnt == '0;

    // Interrupt set by a landed event, held until cleared
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            irq <= 1'b0;
        else if (!run)
            irq <= 1'b0;
        else if (ie && wr_q && !empty)
            irq <= 1'b1;
        else if (irq_clr)
            irq <= 1'b0;
    end

    // Credits keep the FIFO from filling up
    a_no_full_wr : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        wr_en |-> cnt != CNT_W'(`HPD_QUEUE_DEPTH));

endmodule

/* hw/dp_hpd_top.sv */
`timescale 1ns/1ps
`include "hpd_consts.svh"

module dp_hpd_top
(
    input  logic                  CLK_IN,
    input  logic                  RST_IN,
    input  logic [1:0]            lb_adr,
    input  logic                  lb_wr,
    input  logic                  lb_rd,
    input  logic [31:0]           lb_din,
    output logic [31:0]           lb_dout,
    output logic                  lb_vld,
    input  logic [`HPD_PORTS-1:0] hpd,
    output logic                  irq
);

    logic                  beat;
    logic                  run;
    logic                  ie;
    logic [`HPD_PORTS-1:0] force_hpd;
    logic [`HPD_PORTS-1:0] ovf_clr;
    logic                  pop;
    logic                  irq_clr;
    logic [`HPD_PORTS-1:0] hpd_lvl;
    logic [`HPD_PORTS-1:0] ovf;
    dp_hpd_pkg::hpd_evt_s  head;
    logic                  empty;

    // Event path, one per port
    hpd_evt_if evt_if [`HPD_PORTS] ();

    hpd_lb_regs hpd_lb_regs_i
    (
        .CLK_IN    (CLK_IN),
        .RST_IN    (RST_IN),
        .lb_adr    (lb_adr),
        .lb_wr     (lb_wr),
        .lb_rd     (lb_rd),
        .lb_din    (lb_din),
        .lb_dout   (lb_dout),
        .lb_vld    (lb_vld),
        .beat      (beat),
        .run       (run),
        .ie        (ie),
        .force_hpd (force_hpd),
        .ovf_clr   (ovf_clr),
        .pop       (pop),
        .irq_clr   (irq_clr),
        .hpd_lvl   (hpd_lvl),
        .ovf       (ovf),
        .head      (head),
        .empty     (empty),
        .irq_in    (irq)
    );

    for (genvar i = 0; i < `HPD_PORTS; i++)
    begin : g_det
        hpd_detector hpd_detector_i
        (
            .CLK_IN    (CLK_IN),
            .RST_IN    (RST_IN),
            .beat      (beat),
            .run       (run),
            .force_hpd (force_hpd[i]),
            .hpd_raw   (hpd[i]),
            .ovf_clr   (ovf_clr[i]),
            .hpd_lvl   (hpd_lvl[i]),
            .evt       (evt_if[i])
        );
    end

    hpd_event_queue hpd_event_queue_i
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .run     (run),
        .pop     (pop),
        .irq_clr (irq_clr),
        .ie      (ie),
        .evt     (evt_if),
        .head    (head),
        .empty   (empty),
        .irq     (irq),
        .ovf     (ovf)
    );

endmodule

/* dv/dp_hpd_tb.sv */
`timescale 1ns/1ps
`include "hpd_consts.svh"

module dp_hpd_tb;

    // Limits in clock cycles
    localparam int MARGIN_CYC   = 2000;
    localparam int IRQ_WAIT_CYC = 400 * `HPD_BEAT_DIV;

    logic        CLK_IN = 1'b0;
    logic        RST_IN;
    logic [1:0]  lb_adr;
    logic        lb_wr;
    logic        lb_rd;
    logic [31:0] lb_din;
    logic [31:0] lb_dout;
    logic        lb_vld;
    logic [3:0]  hpd;
    logic        irq;

    // Parsed stimulus, one entry per file line
    string       step_test [$];
    string       step_cmd [$];
    int          step_a [$];
    logic [31:0] step_b [$];

    int cycle_limit = 0;
    int errors      = 0;
    int checks      = 0;
    int tests       = 0;
    int test_base   = 0;

    // 20 ns period
    always #10 CLK_IN = ~CLK_IN;

    dp_hpd_top dp_hpd_top_i
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .lb_adr  (lb_adr),
        .lb_wr   (lb_wr),
        .lb_rd   (lb_rd),
        .lb_din  (lb_din),
        .lb_dout (lb_dout),
        .lb_vld  (lb_vld),
        .hpd     (hpd),
        .irq     (irq)
    );

    // Watchdog, armed once the limit is known
    initial
    begin
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit)
        begin
            @(posedge CLK_IN);
            cycles++;
        end
        $display("Run stopped after %0d cycles, the DUT stalled", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    // Read all steps, sum the beat waits
    task automatic load_stim(output bit ok, output int beats);
        int          fd;
        int          n;
        string       line;
        string       t;
        string       c;
        int          a;
        logic [31:0] b;
        ok    = 1'b0;
        beats = 0;
        fd    = $fopen("dv/hpd_stim.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                // Skip blanks and comment lines
                if (n > 1 && line.getc(0) != "#")
                begin
                    a = 0;
                    b = '0;
                    n = $sscanf(line, "%s %s %d %h", t, c, a, b);
                    if (n >= 2)
                    begin
                        step_test.push_back(t);
                        step_cmd.push_back(c);
                        step_a.push_back(a);
                        step_b.push_back(b);
                        if (c == "B")
                            beats += a;
                    end
                end
            end
            $fclose(fd);
            ok = step_test.size() > 0;
        end
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [31:0] data);
        repeat ($urandom % 4) @(posedge CLK_IN);
        @(posedge CLK_IN);
        lb_adr <= adr;
        lb_din <= data;
        lb_wr  <= 1'b1;
        @(posedge CLK_IN);
        lb_wr  <= 1'b0;
    endtask

    // lb_vld sampled at the falling edge, a single pulse the cycle after lb_rd
    task automatic bus_read(input logic [1:0] adr, output logic [31:0] data, output logic ok);
        repeat ($urandom % 4) @(posedge CLK_IN);
        @(posedge CLK_IN);
        lb_adr <= adr;
        lb_rd  <= 1'b1;
        @(posedge CLK_IN);
        lb_rd  <= 1'b0;
        @(negedge CLK_IN);
        ok   = lb_vld;
        data = lb_dout;
        // Must be gone one cycle later
        @(negedge CLK_IN);
        ok = ok && !lb_vld;
    endtask

    task automatic check_read(input string name, input logic ok, input logic [31:0] exp,
                              input logic [31:0] got);
        checks++;
        assert (ok)
        else
        begin
            $display("%s: lb_vld was not a single pulse one cycle after the read", name);
            errors++;
        end
        if (ok)
        begin
            assert (got == exp)
            else
            begin
                $display("FAIL %s: expected %h, actual %h", name, exp, got);
                errors++;
            end
        end
    endtask

    task automatic wait_irq(input string name);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        checks++;
        while (!seen && n < IRQ_WAIT_CYC)
        begin
            @(negedge CLK_IN);
            seen = irq;
            n++;
        end
        assert (seen)
        else
        begin
            $display("%s: irq did not rise within %0d cycles", name, IRQ_WAIT_CYC);
            errors++;
        end
    endtask

    // One command from the file
    task automatic run_step(input string name, input string cmd, input int a,
                            input logic [31:0] b);
        logic [31:0] got;
        logic        ok;
        case (cmd)
            "W" : bus_write(a[1:0], b);
            "R" :
            begin
                bus_read(a[1:0], got, ok);
                check_read(name, ok, b, got);
            end
            "H" :
            begin
                @(posedge CLK_IN);
                hpd <= a[3:0];
            end
            "B" : repeat (a * `HPD_BEAT_DIV) @(posedge CLK_IN);
            "I" : wait_irq(name);
            default :
            begin
                $display("%s: unknown command %s in stimulus", name, cmd);
                errors++;
            end
        endcase
    endtask

    task automatic end_test(input string name);
        if (errors == test_base)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - test_base);
    endtask

    initial
    begin
        bit    loaded;
        int    beats;
        string cur;
        RST_IN = 1'b1;
        lb_adr = '0;
        lb_wr  = 1'b0;
        lb_rd  = 1'b0;
        lb_din = '0;
        hpd    = '0;
        cur    = "";
        void'($urandom(32'h2264a6b3));
        load_stim(loaded, beats);
        if (loaded)
        begin
            cycle_limit = beats * `HPD_BEAT_DIV + MARGIN_CYC;
            repeat (8) @(posedge CLK_IN);
            RST_IN <= 1'b0;
            foreach (step_test[i])
            begin
                // New name starts a new test
                if (step_test[i] != cur)
                begin
                    if (cur != "")
                        end_test(cur);
                    cur       = step_test[i];
                    test_base = errors;
                    tests++;
                end
                run_step(step_test[i], step_cmd[i], step_a[i], step_b[i]);
            end
            if (cur != "")
                end_test(cur);
        end
        else
        begin
            $display("Could not read any steps from dv/hpd_stim.txt");
            errors++;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* all.f */
+incdir+hw
hw/dp_hpd_pkg.sv
hw/dp_lb_pkg.sv
hw/hpd_evt_if.sv
hw/hpd_lb_regs.sv
hw/hpd_detector.sv
hw/hpd_event_queue.sv
hw/dp_hpd_top.sv
dv/dp_hpd_tb.sv

/* dv/hpd_stim.txt */
# test  cmd  a (decimal: address, hpd vector or beats)  b (hex: write data or expected read)
# W adr data | R adr expected | H hpd 0 | B beats 0 | I 0 0 (wait for irq)
reset R 0 0
reset R 1 2
reset R 2 100
start W 0 3
start R 0 3
start I 0 0
start R 2 1
start R 2 5
start R 2 9
start R 2 d
start R 2 100
start R 1 3
start W 1 1
start R 1 2
plug H 2 0
plug B 40 0
plug I 0 0
plug R 2 6
plug R 1 b
plug W 1 1
plug R 1 a
force W 0 13
force R 0 13
force B 30 0
force I 0 0
force R 2 a
force R 1 1b
force W 1 1
pulse H 0 0
pulse B 60 0
pulse H 2 0
pulse I 0 0
pulse R 2 7
pulse W 1 1
glitch H 0 0
glitch B 20 0
glitch H 2 0
glitch B 10 0
glitch R 1 1a
glitch R 2 100
unplug H 0 0
unplug B 250 0
unplug I 0 0
unplug R 2 5
unplug R 1 13
unplug W 1 1
overflow H 1 0
overflow B 32 0
overflow H 0 0
overflow B 215 0
overflow H 1 0
overflow B 32 0
overflow H 0 0
overflow B 215 0
overflow H 1 0
overflow B 32 0
overflow H 0 0
overflow B 215 0
overflow H 1 0
overflow B 32 0
overflow H 0 0
overflow B 215 0
overflow R 2 2
overflow R 2 1
overflow R 2 2
overflow R 2 100
overflow R 1 53
overflow W 1 5
overflow R 1 12
